// File: dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// physical byte address
`define DC_ADDR_W   32

// byte offset inside a line, bits 2..0
`define DC_OFFSET_W 3

// set index, bits 8..3
`define DC_INDEX_W  6
`define DC_SETS     (1 << `DC_INDEX_W)

// tag, bits 31..9
`define DC_TAG_W    23

`define DC_LINE_W   64
`define DC_BUS_W    32

`endif

// File: dcache_pkg.sv
package dcache_pkg;

    // read side sequencer
    typedef enum logic [2:0] {
        RD_IDLE,
        RD_LOOKUP,
        RD_FILL_LO,
        RD_FILL_HI,
        RD_NEXT_LINE,
        RD_RESP
    } rd_state_e;

    // store beat sequencer
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_BEAT,
        WR_WAIT_ACK
    } wr_state_e;

    // store width, 1/2/4/8 bytes
    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_HALF  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } wr_size_e;

    // who holds the memory bus
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_READ,
        OWN_WRITE
    } bus_owner_e;

endpackage

// File: dcache_read_path.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_read_path (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_req_valid,
    output logic                  rd_req_ready,
    input  logic [`DC_ADDR_W-1:0] rd_req_address,
    output logic                  rd_dp_valid,
    input  logic                  rd_dp_ready,
    output logic [`DC_LINE_W-1:0] rd_dp_read_data,
    output logic                  fill_req,
    output logic [`DC_ADDR_W-1:0] fill_addr,
    input  logic                  fill_ack,
    input  logic [`DC_BUS_W-1:0]  fill_data,
    input  logic                  snoop_valid,
    input  logic [`DC_ADDR_W-1:0] snoop_addr
);
    import dcache_pkg::*;

    localparam int LA_W = `DC_ADDR_W - `DC_OFFSET_W;

    rd_state_e state;
    logic [`DC_ADDR_W-1:0] req_addr;
    logic second;
    logic fill_stale;
    logic [`DC_BUS_W-1:0] fill_lo;
    logic [`DC_LINE_W-1:0] stage_line;
    logic [`DC_LINE_W-1:0] resp_data;

    logic [`DC_SETS-1:0] valid_bits;
    logic [`DC_TAG_W-1:0] tag_mem [`DC_SETS];
    logic [`DC_LINE_W-1:0] data_mem [`DC_SETS];

    logic [LA_W-1:0] lk_line;
    logic [`DC_INDEX_W-1:0] lk_index;
    logic [`DC_TAG_W-1:0] lk_tag;
    logic [`DC_LINE_W-1:0] lk_data;
    logic lk_hit;
    logic [`DC_OFFSET_W-1:0] offset;
    logic unaligned;
    logic [2*`DC_LINE_W-1:0] pair;
    logic [`DC_LINE_W-1:0] aligned_data;
    logic [`DC_INDEX_W-1:0] sn_index;
    logic [`DC_TAG_W-1:0] sn_tag;
    logic sn_fill_match;

    // second pass looks at the following line
    assign lk_line  = req_addr[`DC_ADDR_W-1:`DC_OFFSET_W] + LA_W'(second);
    assign lk_index = lk_line[`DC_INDEX_W-1:0];
    assign lk_tag   = lk_line[LA_W-1:`DC_INDEX_W];
    assign lk_data  = data_mem[lk_index];
    assign lk_hit   = valid_bits[lk_index] && (tag_mem[lk_index] == lk_tag);

    assign offset    = req_addr[`DC_OFFSET_W-1:0];
    assign unaligned = |offset;

    // staged line is the low half, current line the high half
    assign pair         = {lk_data, stage_line};
    assign aligned_data = pair[{offset, 3'b000} +: `DC_LINE_W];

    assign sn_index      = snoop_addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign sn_tag        = snoop_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign sn_fill_match = snoop_valid && (snoop_addr[`DC_ADDR_W-1:`DC_OFFSET_W] == lk_line);

    assign rd_req_ready    = (state == RD_IDLE);
    assign rd_dp_valid     = (state == RD_RESP);
    assign rd_dp_read_data = resp_data;
    assign fill_req        = (state == RD_FILL_LO) || (state == RD_FILL_HI);
    assign fill_addr       = {lk_line, (state == RD_FILL_HI), 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= RD_IDLE;
            second     <= 1'b0;
            fill_stale <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rd_req_valid) begin
                        state  <= RD_LOOKUP;
                        second <= 1'b0;
                    end
                end
                RD_LOOKUP, RD_NEXT_LINE: begin
                    if (!lk_hit) begin
                        state      <= RD_FILL_LO;
                        fill_stale <= 1'b0;
                    end else if (state == RD_LOOKUP && unaligned) begin
                        state  <= RD_NEXT_LINE;
                        second <= 1'b1;
                    end else begin
                        state <= RD_RESP;
                    end
                end
                RD_FILL_LO: begin
                    if (sn_fill_match)
                        fill_stale <= 1'b1;
                    if (fill_ack)
                        state <= RD_FILL_HI;
                end
                RD_FILL_HI: begin
                    if (sn_fill_match)
                        fill_stale <= 1'b1;
                    if (fill_ack)
                        state <= second ? RD_NEXT_LINE : RD_LOOKUP;
                end
                RD_RESP: begin
                    if (rd_dp_ready)
                        state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_IDLE && rd_req_valid)
            req_addr <= rd_req_address;
        if (state == RD_LOOKUP && lk_hit && unaligned)
            stage_line <= lk_data;
        if (state == RD_LOOKUP && lk_hit && !unaligned)
            resp_data <= lk_data;
        if (state == RD_NEXT_LINE && lk_hit)
            resp_data <= aligned_data;
        if (state == RD_FILL_LO && fill_ack)
            fill_lo <= fill_data;
        if (state == RD_FILL_HI && fill_ack) begin
            data_mem[lk_index] <= {fill_data, fill_lo};
            tag_mem[lk_index]  <= lk_tag;
        end
    end

    // a line written on the bus during its own fill stays invalid
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else begin
            if (state == RD_FILL_HI && fill_ack)
                valid_bits[lk_index] <= !(fill_stale || sn_fill_match);
            if (snoop_valid && tag_mem[sn_index] == sn_tag)
                valid_bits[sn_index] <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        rd_dp_valid && !rd_dp_ready |=> rd_dp_valid && $stable(rd_dp_read_data));

    assert property (@(posedge clk) disable iff (rst)
        rd_dp_valid && !rd_dp_ready |=> !$rose(fill_req));

endmodule

// File: dcache_write_path.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_write_path (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_req_valid,
    output logic                      wr_req_ready,
    input  logic [`DC_ADDR_W-1:0]     wr_req_address,
    input  logic [`DC_LINE_W-1:0]     wr_req_data,
    input  dcache_pkg::wr_size_e      wr_size_in,
    output logic                      beat_req,
    output logic [`DC_ADDR_W-1:0]     beat_addr,
    output logic [`DC_BUS_W/8-1:0]    beat_be,
    output logic [`DC_BUS_W-1:0]      beat_data,
    input  logic                      beat_ack
);
    import dcache_pkg::*;

    localparam int BE_W = `DC_BUS_W / 8;

    wr_state_e state;
    logic [`DC_ADDR_W-1:0] st_addr;
    logic [`DC_LINE_W-1:0] st_data;
    wr_size_e st_size;
    logic [1:0] beat_cnt;

    logic [1:0] start;
    logic [3:0] span;
    logic [3:0] last_byte;
    logic [1:0] last_cnt;
    logic [7:0] size_mask;
    logic [15:0] lane_mask;
    logic [2*`DC_LINE_W-1:0] lane_data;
    logic [`DC_ADDR_W-3:0] word_addr;

    // byte mask and span (bytes minus one) of the store
    always_comb begin
        case (st_size)
            SZ_BYTE: begin
                size_mask = 8'h01;
                span      = 4'd0;
            end
            SZ_HALF: begin
                size_mask = 8'h03;
                span      = 4'd1;
            end
            SZ_WORD: begin
                size_mask = 8'h0f;
                span      = 4'd3;
            end
            default: begin
                size_mask = 8'hff;
                span      = 4'd7;
            end
        endcase
    end

    assign start     = st_addr[1:0];
    assign last_byte = {2'b00, start} + span;
    // index of the last word touched (0 to 2)
    assign last_cnt  = last_byte[3:2];

    // move every byte into the lane of its address
    assign lane_mask = {8'h00, size_mask} << start;
    assign lane_data = {{`DC_LINE_W{1'b0}}, st_data} << {start, 3'b000};
    assign word_addr = st_addr[`DC_ADDR_W-1:2] + (`DC_ADDR_W-2)'(beat_cnt);

    assign wr_req_ready = (state == WR_IDLE);
    assign beat_req     = (state == WR_WAIT_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WR_IDLE;
            beat_cnt <= 2'd0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (wr_req_valid) begin
                        state    <= WR_BEAT;
                        beat_cnt <= 2'd0;
                    end
                end
                WR_BEAT: state <= WR_WAIT_ACK;
                WR_WAIT_ACK: begin
                    if (beat_ack) begin
                        if (beat_cnt == last_cnt) begin
                            state <= WR_IDLE;
                        end else begin
                            state    <= WR_BEAT;
                            beat_cnt <= beat_cnt + 2'd1;
                        end
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WR_IDLE && wr_req_valid) begin
            st_addr <= wr_req_address;
            st_data <= wr_req_data;
            st_size <= wr_size_in;
        end
        // build the beat one cycle ahead of the request
        if (state == WR_BEAT) begin
            beat_addr <= {word_addr, 2'b00};
            beat_be   <= lane_mask[{beat_cnt, 2'b00} +: BE_W];
            beat_data <= lane_data[{beat_cnt, 5'd0} +: `DC_BUS_W];
        end
    end

    // each of the at most three beats carries a byte of the store
    assert property (@(posedge clk) disable iff (rst)
        beat_req |-> (beat_cnt <= 2'd2) && (beat_be != '0));

endmodule

// File: dcache_bus_arbiter.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_bus_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fill_req,
    input  logic [`DC_ADDR_W-1:0]  fill_addr,
    output logic                   fill_ack,
    output logic [`DC_BUS_W-1:0]   fill_data,
    input  logic                   beat_req,
    input  logic [`DC_ADDR_W-1:0]  beat_addr,
    input  logic [`DC_BUS_W/8-1:0] beat_be,
    input  logic [`DC_BUS_W-1:0]   beat_data,
    output logic                   beat_ack,
    output logic                   mem_req,
    output logic [`DC_ADDR_W-1:0]  mem_addr,
    output logic                   mem_we,
    output logic [`DC_BUS_W/8-1:0] mem_be,
    output logic [`DC_BUS_W-1:0]   mem_wdata,
    input  logic                   mem_ack,
    input  logic [`DC_BUS_W-1:0]   mem_rdata,
    output logic                   snoop_valid,
    output logic [`DC_ADDR_W-1:0]  snoop_addr
);
    import dcache_pkg::*;

    bus_owner_e owner;
    logic own_wr;

    // write first, then hold until ack and idle one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            owner <= OWN_NONE;
        end else begin
            case (owner)
                OWN_NONE: begin
                    if (beat_req)
                        owner <= OWN_WRITE;
                    else if (fill_req)
                        owner <= OWN_READ;
                end
                default: begin
                    if (mem_ack)
                        owner <= OWN_NONE;
                end
            endcase
        end
    end

    assign own_wr = (owner == OWN_WRITE);

    assign mem_req   = (owner != OWN_NONE);
    assign mem_we    = own_wr;
    assign mem_addr  = own_wr ? beat_addr : fill_addr;
    assign mem_be    = own_wr ? beat_be : '1;
    assign mem_wdata = own_wr ? beat_data : '0;

    assign fill_ack  = mem_ack && (owner == OWN_READ);
    assign fill_data = mem_rdata;
    assign beat_ack  = mem_ack && own_wr;

    // every finished write beat invalidates the matching line
    assign snoop_valid = beat_ack;
    assign snoop_addr  = beat_addr;

    // owner and request fields stay put until the ack
    assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> mem_req && $stable(mem_we) && $stable(mem_addr)
            && $stable(mem_be) && $stable(mem_wdata));

    assert property (@(posedge clk) disable iff (rst)
        mem_ack |=> !mem_req);

endmodule

// File: dcache_top.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module dcache_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_req_valid,
    output logic                   rd_req_ready,
    input  logic [`DC_ADDR_W-1:0]  rd_req_address,
    output logic                   rd_dp_valid,
    input  logic                   rd_dp_ready,
    output logic [`DC_LINE_W-1:0]  rd_dp_read_data,
    input  logic                   wr_req_valid,
    output logic                   wr_req_ready,
    input  logic [`DC_ADDR_W-1:0]  wr_req_address,
    input  logic [`DC_LINE_W-1:0]  wr_req_data,
    input  dcache_pkg::wr_size_e   wr_size_in,
    output logic                   mem_req,
    output logic [`DC_ADDR_W-1:0]  mem_addr,
    output logic                   mem_we,
    output logic [`DC_BUS_W/8-1:0] mem_be,
    output logic [`DC_BUS_W-1:0]   mem_wdata,
    input  logic                   mem_ack,
    input  logic [`DC_BUS_W-1:0]   mem_rdata
);
    logic fill_req;
    logic [`DC_ADDR_W-1:0] fill_addr;
    logic fill_ack;
    logic [`DC_BUS_W-1:0] fill_data;
    logic beat_req;
    logic [`DC_ADDR_W-1:0] beat_addr;
    logic [`DC_BUS_W/8-1:0] beat_be;
    logic [`DC_BUS_W-1:0] beat_data;
    logic beat_ack;
    logic snoop_valid;
    logic [`DC_ADDR_W-1:0] snoop_addr;

    dcache_read_path u_read (
        .clk, .rst,
        .rd_req_valid, .rd_req_ready, .rd_req_address,
        .rd_dp_valid, .rd_dp_ready, .rd_dp_read_data,
        .fill_req, .fill_addr, .fill_ack, .fill_data,
        .snoop_valid, .snoop_addr
    );

    dcache_write_path u_write (
        .clk, .rst,
        .wr_req_valid, .wr_req_ready, .wr_req_address, .wr_req_data, .wr_size_in,
        .beat_req, .beat_addr, .beat_be, .beat_data, .beat_ack
    );

    dcache_bus_arbiter u_arb (
        .clk, .rst,
        .fill_req, .fill_addr, .fill_ack, .fill_data,
        .beat_req, .beat_addr, .beat_be, .beat_data, .beat_ack,
        .mem_req, .mem_addr, .mem_we, .mem_be, .mem_wdata, .mem_ack, .mem_rdata,
        .snoop_valid, .snoop_addr
    );

endmodule

// File: tb_mem_model.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module tb_mem_model #(
    parameter int AW = 12
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_req,
    input  logic [`DC_ADDR_W-1:0]  mem_addr,
    input  logic                   mem_we,
    input  logic [`DC_BUS_W/8-1:0] mem_be,
    input  logic [`DC_BUS_W-1:0]   mem_wdata,
    output logic                   mem_ack,
    output logic [`DC_BUS_W-1:0]   mem_rdata,
    output int                     rd_count,
    output int                     wr_count
);
    logic [7:0] mem_bytes [0:(1 << AW)-1];
    integer seed;
    int wait_cnt;
    int i;
    int b;
    logic busy;
    logic [AW-1:0] base;

    // same seed and fill order as the testbench reference array
    initial begin
        seed      = 17918;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        for (i = 0; i < (1 << AW); i++)
            mem_bytes[i] = $random(seed);
    end

    assign base = {mem_addr[AW-1:2], 2'b00};

    always @(posedge clk) begin
        if (rst) begin
            mem_ack  <= 1'b0;
            busy     <= 1'b0;
            wait_cnt <= 0;
            rd_count <= 0;
            wr_count <= 0;
        end else begin
            mem_ack <= 1'b0;
            if (mem_ack) begin
                busy <= 1'b0;
            end else if (mem_req && !busy) begin
                // ack comes 1 to 4 cycles later
                busy     <= 1'b1;
                wait_cnt <= 1 + ($unsigned($random(seed)) % 4);
            end else if (busy) begin
                if (wait_cnt == 1) begin
                    mem_ack <= 1'b1;
                    if (mem_we) begin
                        for (b = 0; b < 4; b++)
                            if (mem_be[b])
                                mem_bytes[base + b] <= mem_wdata[8*b +: 8];
                        wr_count <= wr_count + 1;
                    end else begin
                        mem_rdata <= {mem_bytes[base + 3], mem_bytes[base + 2],
                                      mem_bytes[base + 1], mem_bytes[base]};
                        rd_count  <= rd_count + 1;
                    end
                end
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

// File: tb_dcache.sv
`timescale 1ns/10ps
`include "dcache_params.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int MEM_AW    = 12;
    localparam int MEM_BYTES = 1 << MEM_AW;
    localparam int TIMEOUT   = 200;

    logic clk;
    logic rst;
    logic rd_req_valid;
    logic rd_req_ready;
    logic [`DC_ADDR_W-1:0] rd_req_address;
    logic rd_dp_valid;
    logic rd_dp_ready;
    logic [`DC_LINE_W-1:0] rd_dp_read_data;
    logic wr_req_valid;
    logic wr_req_ready;
    logic [`DC_ADDR_W-1:0] wr_req_address;
    logic [`DC_LINE_W-1:0] wr_req_data;
    wr_size_e wr_size_in;
    logic mem_req;
    logic [`DC_ADDR_W-1:0] mem_addr;
    logic mem_we;
    logic [`DC_BUS_W/8-1:0] mem_be;
    logic [`DC_BUS_W-1:0] mem_wdata;
    logic mem_ack;
    logic [`DC_BUS_W-1:0] mem_rdata;
    int rd_count;
    int wr_count;

    integer seed;
    int i;
    logic [7:0] golden [0:MEM_BYTES-1];
    logic [`DC_BUS_W/8-1:0] be_log [$];

    dcache_top DUT (.*);

    tb_mem_model #(.AW(MEM_AW)) u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // byte enables of every acknowledged write beat
    always @(posedge clk) begin
        if (mem_req && mem_ack && mem_we)
            be_log.push_back(mem_be);
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [`DC_LINE_W-1:0] exp,
                              input logic [`DC_LINE_W-1:0] act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            stop_on_error($sformatf("mismatch %s expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_be(input string name, input logic [`DC_BUS_W/8-1:0] exp,
                            input logic [`DC_BUS_W/8-1:0] act);
        if (act !== exp)
            stop_on_error($sformatf("mismatch %s expected %b actual %b", name, exp, act));
    endtask

    function automatic int size_bytes(input wr_size_e sz);
        case (sz)
            SZ_BYTE: return 1;
            SZ_HALF: return 2;
            SZ_WORD: return 4;
            default: return 8;
        endcase
    endfunction

    function automatic logic [`DC_LINE_W-1:0] golden_dword(input int addr);
        logic [`DC_LINE_W-1:0] d;
        int k;
        for (k = 0; k < 8; k++)
            d[8*k +: 8] = golden[addr + k];
        return d;
    endfunction

    function automatic logic [`DC_LINE_W-1:0] memory_dword(input int addr);
        logic [`DC_LINE_W-1:0] d;
        int k;
        for (k = 0; k < 8; k++)
            d[8*k +: 8] = u_mem.mem_bytes[addr + k];
        return d;
    endfunction

    // latency counts edges from acceptance until the response is seen
    task automatic do_read(input int addr, input int hold,
                           output logic [`DC_LINE_W-1:0] data, output int latency);
        int n;
        int k;
        @(posedge clk);
        #1;
        rd_req_valid   = 1'b1;
        rd_req_address = addr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                stop_on_error("timeout: read request was never accepted");
        end while (!rd_req_ready);
        #1;
        rd_req_valid = 1'b0;
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
            if (latency > TIMEOUT)
                stop_on_error("timeout: read response never became valid");
        end while (!rd_dp_valid);
        data = rd_dp_read_data;
        for (k = 0; k < hold; k++) begin
            @(posedge clk);
            check_count("backpressure valid", 1, rd_dp_valid);
            check_data("backpressure data", data, rd_dp_read_data);
        end
        #1;
        rd_dp_ready = 1'b1;
        @(posedge clk);
        #1;
        rd_dp_ready = 1'b0;
    endtask

    task automatic do_write(input int addr, input logic [`DC_LINE_W-1:0] data,
                            input wr_size_e sz);
        int n;
        int k;
        @(posedge clk);
        #1;
        wr_req_valid   = 1'b1;
        wr_req_address = addr;
        wr_req_data    = data;
        wr_size_in     = sz;
        for (k = 0; k < size_bytes(sz); k++)
            golden[addr + k] = data[8*k +: 8];
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                stop_on_error("timeout: store was never accepted");
        end while (!wr_req_ready);
        #1;
        wr_req_valid = 1'b0;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > TIMEOUT)
                stop_on_error("timeout: store never completed on the bus");
        end while (!wr_req_ready);
    endtask

    task automatic test_read_miss_hit();
        logic [`DC_LINE_W-1:0] data;
        int lat;
        int rd0;
        rd0 = rd_count;
        do_read('h100, 0, data, lat);
        check_data("read_miss_hit miss data", golden_dword('h100), data);
        check_count("read_miss_hit miss bus reads", 2, rd_count - rd0);
        rd0 = rd_count;
        do_read('h100, 0, data, lat);
        check_data("read_miss_hit hit data", golden_dword('h100), data);
        check_count("read_miss_hit hit bus reads", 0, rd_count - rd0);
        check_count("read_miss_hit hit latency", 2, lat);
    endtask

    task automatic test_read_unaligned();
        logic [`DC_LINE_W-1:0] data;
        int lat;
        int rd0;
        // neither line cached
        rd0 = rd_count;
        do_read('h205, 0, data, lat);
        check_data("read_unaligned both data", golden_dword('h205), data);
        check_count("read_unaligned both bus reads", 4, rd_count - rd0);
        do_read('h240, 0, data, lat);
        // only the next line is missing
        rd0 = rd_count;
        do_read('h243, 0, data, lat);
        check_data("read_unaligned next data", golden_dword('h243), data);
        check_count("read_unaligned next bus reads", 2, rd_count - rd0);
        rd0 = rd_count;
        do_read('h247, 0, data, lat);
        check_data("read_unaligned cached data", golden_dword('h247), data);
        check_count("read_unaligned cached bus reads", 0, rd_count - rd0);
    endtask

    task automatic test_store_sizes();
        logic [`DC_LINE_W-1:0] data;
        logic [`DC_BUS_W/8-1:0] be_exp;
        wr_size_e sz;
        int addr;
        int n;
        int w;
        int s;
        int o;
        int j;
        int b;
        for (s = 0; s < 4; s++) begin
            for (o = 0; o < 8; o++) begin
                sz   = wr_size_e'(s);
                n    = size_bytes(sz);
                addr = 'h400 + 16 * (8 * s + o) + o;
                data = {$random(seed), $random(seed)};
                be_log.delete();
                do_write(addr, data, sz);
                check_count("store_sizes beats", ((addr + n - 1) >> 2) - (addr >> 2) + 1,
                            be_log.size());
                for (j = 0; j < be_log.size(); j++) begin
                    w = (addr >> 2) + j;
                    for (b = 0; b < 4; b++)
                        be_exp[b] = (4 * w + b >= addr) && (4 * w + b < addr + n);
                    check_be("store_sizes byte enable", be_exp, be_log[j]);
                end
                check_data("store_sizes memory lo", golden_dword(addr & ~7),
                           memory_dword(addr & ~7));
                check_data("store_sizes memory hi", golden_dword((addr & ~7) + 8),
                           memory_dword((addr & ~7) + 8));
            end
        end
    endtask

    task automatic test_store_then_read();
        logic [`DC_LINE_W-1:0] data;
        int lat;
        int rd0;
        do_read('h600, 0, data, lat);
        do_write('h603, 64'h0000_0000_0000_a55a, SZ_HALF);
        rd0 = rd_count;
        do_read('h600, 0, data, lat);
        check_data("store_then_read data", golden_dword('h600), data);
        check_count("store_then_read refill reads", 2, rd_count - rd0);
    endtask

    task automatic test_backpressure();
        logic [`DC_LINE_W-1:0] data;
        int lat;
        do_read('h700, 6, data, lat);
        check_data("backpressure data", golden_dword('h700), data);
        @(posedge clk);
        check_count("backpressure ready after take", 1, rd_req_ready);
    endtask

    task automatic test_random_mix();
        logic [`DC_LINE_W-1:0] data;
        logic [`DC_LINE_W-1:0] exp;
        logic [`DC_LINE_W-1:0] wdata;
        wr_size_e sz;
        int lat;
        int kind;
        int raddr;
        int waddr;
        int k;
        for (k = 0; k < 200; k++) begin
            kind  = $unsigned($random(seed)) % 3;
            sz    = wr_size_e'($unsigned($random(seed)) % 4);
            wdata = {$random(seed), $random(seed)};
            if (kind == 2) begin
                // read low half, store high half, so results do not overlap
                raddr = $unsigned($random(seed)) % 2040;
                waddr = 2048 + $unsigned($random(seed)) % 2040;
                exp   = golden_dword(raddr);
                fork
                    do_read(raddr, 0, data, lat);
                    do_write(waddr, wdata, sz);
                join
                check_data("random_mix paired read", exp, data);
            end else if (kind == 1) begin
                waddr = $unsigned($random(seed)) % 4088;
                do_write(waddr, wdata, sz);
            end else begin
                raddr = $unsigned($random(seed)) % 4088;
                do_read(raddr, 0, data, lat);
                check_data("random_mix read", golden_dword(raddr), data);
            end
        end
        for (k = 0; k < MEM_BYTES; k += 8)
            check_data("random_mix final memory", golden_dword(k), memory_dword(k));
    endtask

    initial begin
        seed = 17918;
        for (i = 0; i < MEM_BYTES; i++)
            golden[i] = $random(seed);
        rst            = 1'b1;
        rd_req_valid   = 1'b0;
        rd_req_address = '0;
        rd_dp_ready    = 1'b0;
        wr_req_valid   = 1'b0;
        wr_req_address = '0;
        wr_req_data    = '0;
        wr_size_in     = SZ_BYTE;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        test_read_miss_hit();
        test_read_unaligned();
        test_store_sizes();
        test_store_then_read();
        test_backpressure();
        test_random_mix();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
dcache_pkg.sv
dcache_read_path.sv
dcache_write_path.sv
dcache_bus_arbiter.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_read_path.sv
      - dcache_write_path.sv
      - dcache_bus_arbiter.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_mem_model.sv
      - tb_dcache.sv
